//--- build.f
+incdir+hw
hw/booth_mul_pkg.sv
hw/booth_pp_if.sv
hw/booth_pp_gen.sv
hw/bk_adder.sv
hw/booth_mul_ctrl.sv
hw/booth_mul_datapath.sv
hw/booth_mul_top.sv
test/booth_mul_props.sv
test/booth_mul_tb.sv

//--- test/booth_mul_tb.sv
//////////////////////////////
// Testbench for the radix-4 Booth multiplier
// Directed plus seeded random vectors from a table
// Checks product, latency, back-pressure and handshake
//////////////////////////////

`default_nettype none

`include "booth_mul_macros.svh"

module booth_mul_tb;

  localparam int LAT       = `MUL_WIDTH / 2 + 1;
  localparam int MAX_STALL = 5;
  localparam int N_RAND    = 20;

  // One table row, expected product filled in when the row is added
  typedef struct packed {
    logic [`MUL_WIDTH-1:0]  a;
    logic [`MUL_WIDTH-1:0]  b;
    logic                   sa;
    logic                   sb;
    int                     stall;
    logic [`PROD_WIDTH-1:0] exp;
  } vec_t;

  logic                   clk;
  logic                   rst_n;
  logic [`MUL_WIDTH-1:0]  op_a;
  logic [`MUL_WIDTH-1:0]  op_b;
  logic                   a_signed;
  logic                   b_signed;
  logic                   in_valid;
  logic                   in_ready;
  logic [`PROD_WIDTH-1:0] product;
  logic                   out_valid;
  logic                   out_ready;

  vec_t vecs[$];
  int   seed = 11756;
  logic table_ready = 1'b0;
  int   product_errs = 0;
  int   latency_errs = 0;
  int   flag_errs = 0;
  int   other_errs = 0;
  int   results_taken = 0;

  booth_mul_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_a      (op_a),
    .op_b      (op_b),
    .a_signed  (a_signed),
    .b_signed  (b_signed),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .product   (product),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Output transfers as seen on the DUT ports
  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      results_taken++;
    end
  end

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  // Extend by flag, multiply as signed, keep the low product bits
  function automatic logic [`PROD_WIDTH-1:0] expected_product(
    input logic [`MUL_WIDTH-1:0] a, input logic [`MUL_WIDTH-1:0] b,
    input logic sa, input logic sb);
    logic signed [`MUL_WIDTH:0]    ea;
    logic signed [`MUL_WIDTH:0]    eb;
    logic signed [`PROD_WIDTH+1:0] full;
    ea   = {sa & a[`MUL_WIDTH-1], a};
    eb   = {sb & b[`MUL_WIDTH-1], b};
    full = ea * eb;
    return full[`PROD_WIDTH-1:0];
  endfunction

  task automatic check_product(input string name, input logic [`PROD_WIDTH-1:0] exp,
                               input logic [`PROD_WIDTH-1:0] act);
    if (act !== exp) begin
      product_errs++;
      $display("ERROR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      latency_errs++;
      $display("ERROR out_valid latency expected %h actual %h at %0t", exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("ERROR %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  //////////////////////////////
  // Vector table
  //////////////////////////////

  task automatic add_entry(input logic [`MUL_WIDTH-1:0] a, input logic [`MUL_WIDTH-1:0] b,
                           input logic sa, input logic sb, input int stall);
    vec_t v;
    v.a     = a;
    v.b     = b;
    v.sa    = sa;
    v.sb    = sb;
    v.stall = stall;
    v.exp   = expected_product(a, b, sa, sb);
    vecs.push_back(v);
  endtask

  task automatic build_table();
    int ra;
    int rb;
    int rs;
    // Unsigned corners
    add_entry(16'h0000, 16'h0000, 1'b0, 1'b0, 0);
    add_entry(16'h0001, 16'h0001, 1'b0, 1'b0, 1);
    add_entry(16'hffff, 16'hffff, 1'b0, 1'b0, 0);
    add_entry(16'hffff, 16'h0001, 1'b0, 1'b0, 2);
    add_entry(16'h0000, 16'hffff, 1'b0, 1'b0, 0);
    add_entry(16'h1234, 16'h5678, 1'b0, 1'b0, 5);
    add_entry(16'h8000, 16'h8000, 1'b0, 1'b0, 3);
    // Signed, most negative value included
    add_entry(16'h8000, 16'h8000, 1'b1, 1'b1, 0);
    add_entry(16'h8000, 16'hffff, 1'b1, 1'b1, 4);
    add_entry(16'hffff, 16'hffff, 1'b1, 1'b1, 0);
    add_entry(16'h7fff, 16'h8000, 1'b1, 1'b1, 1);
    add_entry(16'h7fff, 16'h7fff, 1'b1, 1'b1, 0);
    add_entry(16'h0003, 16'hfffd, 1'b1, 1'b1, 2);
    // Mixed signed and unsigned
    add_entry(16'h8000, 16'hffff, 1'b1, 1'b0, 0);
    add_entry(16'hffff, 16'h8000, 1'b0, 1'b1, 3);
    add_entry(16'hffff, 16'hffff, 1'b1, 1'b0, 0);
    add_entry(16'h8000, 16'h7fff, 1'b0, 1'b1, 1);
    add_entry(16'h0001, 16'hffff, 1'b1, 1'b0, 0);
    add_entry(16'hfffe, 16'h0002, 1'b0, 1'b1, 5);
    add_entry(16'h8001, 16'hc000, 1'b1, 1'b1, 0);
    // Seeded random rows
    for (int k = 0; k < N_RAND; k++) begin
      ra = $random(seed);
      rb = $random(seed);
      rs = $random(seed);
      add_entry(ra[`MUL_WIDTH-1:0], rb[`MUL_WIDTH-1:0], rs[0], rs[1],
                int'(rs[7:4]) % (MAX_STALL + 1));
    end
  endtask

  //////////////////////////////
  // One operation
  //////////////////////////////

  // Entered and left on a falling edge
  task automatic run_entry(input vec_t v);
    int lat;
    while (!in_ready) @(negedge clk);
    op_a     = v.a;
    op_b     = v.b;
    a_signed = v.sa;
    b_signed = v.sb;
    in_valid = 1'b1;
    @(negedge clk);
    check_flag("in_ready", 1'b0, in_ready);
    // Scramble inputs with in_valid still high, must be ignored
    op_a     = ~v.a;
    op_b     = v.b ^ 16'h5a5a;
    a_signed = ~v.sa;
    b_signed = ~v.sb;
    lat = 0;
    while (!out_valid) begin
      @(negedge clk);
      lat++;
    end
    check_latency(LAT, lat);
    in_valid = 1'b0;
    check_product("product", v.exp, product);
    // Back-pressure
    for (int i = 0; i < v.stall; i++) begin
      @(negedge clk);
      check_flag("out_valid", 1'b1, out_valid);
      check_product("product", v.exp, product);
    end
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
    // One result per operation, ready for the next one
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("in_ready", 1'b1, in_ready);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n     = 1'b0;
    op_a      = '0;
    op_b      = '0;
    a_signed  = 1'b0;
    b_signed  = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    // Idle state before any stimulus
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("in_ready", 1'b1, in_ready);
    check_product("product", '0, product);
    foreach (vecs[k]) begin
      run_entry(vecs[k]);
    end
    if (results_taken != vecs.size()) begin
      other_errs++;
      $display("Wrong number of results, took %0d results for %0d operations",
               results_taken, vecs.size());
    end
    $display("errors: product %0d, latency %0d, handshake %0d, other %0d",
             product_errs, latency_errs, flag_errs, other_errs);
    if (product_errs + latency_errs + flag_errs + other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog, twice the worst case per row
  initial begin
    longint limit;
    wait (table_ready);
    limit = longint'(vecs.size()) * (`MUL_WIDTH / 2 + 4 + MAX_STALL) * 8 * 2;
    #(limit);
    $display("Run timed out after %0t, the DUT stopped responding", $time);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/booth_mul_props.sv
//////////////////////////////
// Handshake and result checks for the Booth multiplier
// Bound into booth_mul_top, reports through failing assertions
//////////////////////////////

`default_nettype none

`include "booth_mul_macros.svh"

module booth_mul_props
  import booth_mul_pkg::*;
(
  input logic                   clk,
  input logic                   rst_n,
  input logic                   in_valid,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic [`PROD_WIDTH-1:0] product,
  input mul_state_e             state
);

  // Cycles spent in CALC
  localparam int LAT = `MUL_WIDTH / 2 + 1;

  // Stalled result must hold
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(product))
    else $error("product or out_valid changed while stalled");

  // Never both sides open at once
  a_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(in_ready && out_valid))
    else $error("in_ready and out_valid high together");

  // Accept, then LAT quiet cycles, then the result
  a_lat: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_ready |-> ##1 (!out_valid) [*LAT] ##1 out_valid)
    else $error("out_valid did not follow accept with the expected latency");

  // Step counter keeps CALC for LAT cycles, then SEND
  a_calc: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(state == ST_CALC) |-> (state == ST_CALC) [*LAT] ##1 (state == ST_SEND))
    else $error("CALC did not last the expected number of cycles");

endmodule

bind booth_mul_top booth_mul_props props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .product   (product),
  .state     (ctrl_i.state)
);

`default_nettype wire

//--- hw/booth_mul_top.sv
//////////////////////////////
// Iterative radix-4 Booth multiplier top level
// Valid/ready on operands and product
// Result after MUL_WIDTH/2+1 cycles of calculation
//////////////////////////////

`default_nettype none

`include "booth_mul_macros.svh"

module booth_mul_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Operand side
  input  logic [`MUL_WIDTH-1:0]  op_a,
  input  logic [`MUL_WIDTH-1:0]  op_b,
  input  logic                   a_signed,
  input  logic                   b_signed,
  input  logic                   in_valid,
  output logic                   in_ready,
  // Product side
  output logic [`PROD_WIDTH-1:0] product,
  output logic                   out_valid,
  input  logic                   out_ready
);

  logic load;
  logic step;

  booth_pp_if pp_bus ();

  booth_mul_ctrl ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .load      (load),
    .step      (step)
  );

  booth_mul_datapath dp_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_a     (op_a),
    .op_b     (op_b),
    .a_signed (a_signed),
    .b_signed (b_signed),
    .load     (load),
    .step     (step),
    .product  (product),
    .pp_bus   (pp_bus.dp)
  );

  // Digit decode and partial-product select
  booth_pp_gen gen_i (
    .pp_bus (pp_bus.gen)
  );

endmodule

`default_nettype wire

//--- hw/booth_mul_datapath.sv
//////////////////////////////
// Booth multiplier datapath
// Holds operands and accumulator, one digit retired per step
// Partial product comes back through booth_pp_if
//////////////////////////////

`default_nettype none

`include "booth_mul_macros.svh"

module booth_mul_datapath (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`MUL_WIDTH-1:0]  op_a,
  input  logic [`MUL_WIDTH-1:0]  op_b,
  input  logic                   a_signed,
  input  logic                   b_signed,
  input  logic                   load,
  input  logic                   step,
  output logic [`PROD_WIDTH-1:0] product,
  booth_pp_if.dp                 pp_bus
);

  logic                   a_sign;
  logic                   b_sign;
  // Multiplicand with extension bit
  logic [`MUL_WIDTH:0]    mcand_q;
  // {sign, sign, multiplier, 0}, top three bits form the current group
  logic [`MUL_WIDTH+2:0]  mplier_q;
  logic [`PROD_WIDTH-1:0] acc_q;
  logic [`PROD_WIDTH-1:0] acc_shl;
  logic [`PROD_WIDTH-1:0] acc_sum;

  // Unsigned operands extend with zero
  assign a_sign = a_signed & op_a[`MUL_WIDTH-1];
  assign b_sign = b_signed & op_b[`MUL_WIDTH-1];

  //////////////////////////////
  // Operand registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {a_sign, op_a};
      mplier_q <= {{2{b_sign}}, op_b, 1'b0};
    end else if (step) begin
      // Next lower digit moves to the top
      mplier_q <= {mplier_q[`MUL_WIDTH:0], 2'b00};
    end
  end

  assign pp_bus.group = mplier_q[`MUL_WIDTH+2:`MUL_WIDTH];
  assign pp_bus.mcand = mcand_q;

  //////////////////////////////
  // Accumulator
  //////////////////////////////

  // MSB digit first, so earlier sums gain weight 4 each step
  assign acc_shl = {acc_q[`PROD_WIDTH-3:0], 2'b00};

  bk_adder #(
    .WIDTH (`PROD_WIDTH)
  ) adder_i (
    .a   (acc_shl),
    .b   (pp_bus.pp),
    .cin (pp_bus.neg),
    .sum (acc_sum)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (load) begin
      acc_q <= '0;
    end else if (step) begin
      acc_q <= acc_sum;
    end
  end

  // Stable in SEND since no step happens there
  assign product = acc_q;

endmodule

`default_nettype wire

//--- hw/booth_mul_ctrl.sv
//////////////////////////////
// IDLE/CALC/SEND controller of the Booth multiplier
// Issues load on accept and one step per CALC cycle
// Drives both handshake outputs straight from the state
//////////////////////////////

`default_nettype none

`include "booth_mul_macros.svh"

module booth_mul_ctrl
  import booth_mul_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic out_ready,
  output logic in_ready,
  output logic out_valid,
  output logic load,
  output logic step
);

  mul_state_e          state;
  mul_state_e          state_nxt;
  logic [`STEP_W-1:0]  step_cnt;
  logic                last_step;

  // Counter reaches zero on the final digit
  assign last_step = (step_cnt == '0);

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (in_valid)  state_nxt = ST_CALC;
      ST_CALC: if (last_step) state_nxt = ST_SEND;
      ST_SEND: if (out_ready) state_nxt = ST_IDLE;
      default:                state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Loaded with MUL_WIDTH/2 so CALC lasts MUL_WIDTH/2+1 cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_cnt <= '0;
    end else if (load) begin
      step_cnt <= `STEP_W'(`MUL_WIDTH / 2);
    end else if (step) begin
      step_cnt <= step_cnt - 1'b1;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign in_ready  = (state == ST_IDLE);
  assign out_valid = (state == ST_SEND);
  // Input transfer only happens in IDLE
  assign load      = in_ready && in_valid;
  assign step      = (state == ST_CALC);

endmodule

`default_nettype wire

//--- hw/bk_adder.sv
//////////////////////////////
// Brent-Kung parallel prefix adder with carry-in
// WIDTH must be a power of two, carry-out is not produced
// Sum wraps modulo 2**WIDTH
//////////////////////////////

`default_nettype none

module bk_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic [WIDTH-1:0] sum
);

  // Up-sweep levels, then one fewer down-sweep levels
  localparam int LVLS = $clog2(WIDTH);
  localparam int NSTG = 2 * LVLS - 1;

  logic [WIDTH-1:0]            p0;
  logic [NSTG:0][WIDTH-1:0]    gs;
  logic [NSTG:0][WIDTH-1:0]    ps;
  logic [WIDTH-1:0]            carry;

  //////////////////////////////
  // Bitwise generate and propagate
  //////////////////////////////

  assign p0    = a ^ b;
  assign ps[0] = p0;
  // Carry-in folded into bit 0 generate
  assign gs[0] = (a & b) | {{(WIDTH-1){1'b0}}, p0[0] & cin};

  //////////////////////////////
  // Prefix tree
  //////////////////////////////

  for (genvar s = 1; s <= NSTG; s++) begin : g_stage
    // Stages 1..LVLS sweep up, the rest sweep back down
    localparam int LVL  = (s <= LVLS) ? (s - 1) : (NSTG - s);
    localparam int SPAN = 1 << LVL;

    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
      // Up-sweep merges the block ending at bit i with its left neighbour
      localparam bit UP = (s <= LVLS) && (((i + 1) % (2 * SPAN)) == 0);
      // Down-sweep fills the midpoints left open by the up-sweep
      localparam bit DN = (s > LVLS) && (((i + 1) % (2 * SPAN)) == SPAN) &&
                          (i >= 2 * SPAN);

      if (UP || DN) begin : g_cell
        assign gs[s][i] = gs[s-1][i] | (ps[s-1][i] & gs[s-1][i-SPAN]);
        assign ps[s][i] = ps[s-1][i] & ps[s-1][i-SPAN];
      end else begin : g_pass
        assign gs[s][i] = gs[s-1][i];
        assign ps[s][i] = ps[s-1][i];
      end
    end
  end

  // Group generate over [i:0] is the carry out of bit i
  assign carry = gs[NSTG];

  // Top carry is the carry-out and falls off here
  assign sum = p0 ^ {carry[WIDTH-2:0], cin};

endmodule

`default_nettype wire

//--- hw/booth_pp_gen.sv
//////////////////////////////
// Radix-4 Booth partial-product generator
// Purely combinational, sits on the gen side of booth_pp_if
//////////////////////////////

`default_nettype none

`include "booth_mul_macros.svh"

module booth_pp_gen
  import booth_mul_pkg::*;
(
  booth_pp_if.gen pp_bus
);

  booth_op_e              op;
  logic [`PROD_WIDTH-1:0] mcand_1x;
  logic [`PROD_WIDTH-1:0] mcand_2x;

  //////////////////////////////
  // Digit decode
  //////////////////////////////

  always_comb begin
    case (pp_bus.group)
      3'b001, 3'b010: op = OP_ADD1;
      3'b011:         op = OP_ADD2;
      3'b100:         op = OP_SUB2;
      3'b101, 3'b110: op = OP_SUB1;
      // 000 and 111 contribute nothing
      default:        op = OP_ZERO;
    endcase
  end

  //////////////////////////////
  // Operand select
  //////////////////////////////

  // Sign-extend multiplicand to the accumulator width
  assign mcand_1x = {{(`PROD_WIDTH - `MUL_WIDTH - 1){pp_bus.mcand[`MUL_WIDTH]}}, pp_bus.mcand};
  assign mcand_2x = {mcand_1x[`PROD_WIDTH-2:0], 1'b0};

  always_comb begin
    case (op)
      OP_ADD1: pp_bus.pp = mcand_1x;
      OP_ADD2: pp_bus.pp = mcand_2x;
      // One's complement here, the +1 rides on neg
      OP_SUB1: pp_bus.pp = ~mcand_1x;
      OP_SUB2: pp_bus.pp = ~mcand_2x;
      default: pp_bus.pp = '0;
    endcase
  end

  assign pp_bus.neg = (op == OP_SUB1) || (op == OP_SUB2);

endmodule

`default_nettype wire

//--- hw/booth_pp_if.sv
//////////////////////////////
// Link between datapath and partial-product generator
// Datapath uses modport dp, generator uses modport gen
//////////////////////////////

`default_nettype none

`include "booth_mul_macros.svh"

interface booth_pp_if;

  // Booth group, top three multiplier bits
  logic [2:0]               group;
  // Multiplicand with its sign bit on top
  logic [`MUL_WIDTH:0]      mcand;
  // Selected partial product, already inverted for subtraction
  logic [`PROD_WIDTH-1:0]   pp;
  // Carry-in that completes the two's complement
  logic                     neg;

  modport dp  (output group, output mcand, input pp, input neg);
  modport gen (input group, input mcand, output pp, output neg);

endinterface

`default_nettype wire

//--- hw/booth_mul_pkg.sv
//////////////////////////////
// Shared types of the Booth multiplier
// Decoded digit action and controller state encoding
// Import with a wildcard import in the module header
//////////////////////////////

`default_nettype none

`include "booth_mul_macros.svh"

package booth_mul_pkg;

  // Action selected by one radix-4 Booth digit
  typedef enum logic [2:0] {
    OP_ZERO = 3'd0,
    OP_ADD1 = 3'd1,
    OP_ADD2 = 3'd2,
    OP_SUB1 = 3'd3,
    OP_SUB2 = 3'd4
  } booth_op_e;

  // Controller states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_SEND = 2'd2
  } mul_state_e;

endpackage

`default_nettype wire

//--- hw/booth_mul_macros.svh
//////////////////////////////
// Width settings for the radix-4 Booth multiplier
// Include wherever an operand, product or step width is needed
// MUL_WIDTH must stay even
//////////////////////////////

`ifndef BOOTH_MUL_MACROS_SVH
`define BOOTH_MUL_MACROS_SVH

// Operand width of op_a and op_b
`define MUL_WIDTH 16

// Product and accumulator width
`define PROD_WIDTH (2 * `MUL_WIDTH)

// Step counter width, holds MUL_WIDTH/2 down to zero
`define STEP_W 4

`endif
